/* program.hex */
// One instruction word per line, word addresses 0 to 63 in order.
005aff13
015afe13
025afd13
035afc13
045afb13
055afa13
065af913
075af813
085af713
095af613
0a5af513
0b5af413
0c5af313
0d5af213
0e5af113
0f5af013
105aef13
115aee13
125aed13
135aec13
145aeb13
155aea13
165ae913
175ae813
185ae713
195ae613
1a5ae513
1b5ae413
1c5ae313
1d5ae213
1e5ae113
1f5ae013
205adf13
215ade13
225add13
235adc13
245adb13
255ada13
265ad913
275ad813
285ad713
295ad613
2a5ad513
2b5ad413
2c5ad313
2d5ad213
2e5ad113
2f5ad013
305acf13
315ace13
325acd13
335acc13
345acb13
355aca13
365ac913
375ac813
385ac713
395ac613
3a5ac513
3b5ac413
3c5ac313
3d5ac213
3e5ac113
3f5ac013

/* tb.f */
logic/ifu_pkg.sv
logic/inst_mem.sv
logic/icache.sv
logic/fetch_unit.sv
logic/fetch_top.sv
testbench/fetch_assert.sv
testbench/fetch_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the fetch testbench with Verilator, run it and judge the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module fetch_tb -f tb.f -o fetch_sim \
    && ./obj_dir/fetch_sim +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log 2> /dev/null
grep -q "^Testbench passed$" sim.log && echo "Run OK" || { echo "Run FAILED, see sim.log"; exit 1; }

/* testbench/fetch_tb.sv */
module fetch_tb;

    logic                                 clk;
    logic                                 rst;
    logic                                 stall;
    logic                                 redirect;
    logic [ifu_pkg::addr_width-1:0]       redirect_pc;
    logic [ifu_pkg::data_width-1:0]       instr;
    logic [ifu_pkg::addr_width-1:0]       instr_pc;
    logic                                 instr_valid;
    logic [ifu_pkg::counter_width-1:0]    hit_count;
    logic [ifu_pkg::counter_width-1:0]    miss_count;

    integer seed = 67465;
    int     errors = 0;

    fetch_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Helpers
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic finish_run();
        int total;
        total = errors + UUT.u_fetch_assert.assert_errors;
        $display("Errors: %0d testbench, %0d assertion", errors, UUT.u_fetch_assert.assert_errors);
        if (total == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    endtask

    task automatic wait_for_pc(input logic [ifu_pkg::addr_width-1:0] pc);
        int cycles;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!(instr_valid && instr_pc == pc) && cycles < 40);
        if (!(instr_valid && instr_pc == pc)) begin
            errors++;
            $display("Timed out waiting for the instruction at pc %h", pc);
        end
    endtask

    // Lets the stream run from first to last, then holds it with stall.
    task automatic fetch_range(input logic [31:0] first, input logic [31:0] last);
        logic [31:0] a;
        stall <= 1'b0;
        if (first == last) begin
            @(posedge clk);
            stall <= 1'b1;
        end
        for (a = first; a <= last; a += ifu_pkg::pc_step) begin
            wait_for_pc(a);
            if (a + ifu_pkg::pc_step == last) begin
                stall <= 1'b1;
            end
        end
    endtask

    task automatic redirect_to(input logic [ifu_pkg::addr_width-1:0] pc);
        @(posedge clk);
        redirect    <= 1'b1;
        redirect_pc <= pc;
        @(posedge clk);
        redirect    <= 1'b0;
    endtask

    task automatic check_counts(input logic [15:0] hits, input logic [15:0] misses);
        if (hit_count !== hits) begin
            errors++;
            $display("CHECK FAILED hit_count: got %h, expected %h", hit_count, hits);
        end
        if (miss_count !== misses) begin
            errors++;
            $display("CHECK FAILED miss_count: got %h, expected %h", miss_count, misses);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Stimulus
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        int count;
        int cycles;
        rst         = 1'b1;
        stall       = 1'b0;
        redirect    = 1'b0;
        redirect_pc = '0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;

        // Cold pass misses every line, the second pass hits every line.
        fetch_range(32'h00, 32'h3c);
        redirect_to(32'h00);
        fetch_range(32'h00, 32'h3c);
        check_counts(16'd16, 16'd16);

        // 0x40 shares line 0 with address 0, so both evict each other.
        redirect_to(32'h40);
        fetch_range(32'h40, 32'h40);
        redirect_to(32'h00);
        fetch_range(32'h00, 32'h00);
        check_counts(16'd16, 16'd18);

        // Random back-pressure on the sequential stream.
        count  = 0;
        cycles = 0;
        while (count < 24 && cycles < 2000) begin
            @(posedge clk);
            cycles++;
            stall <= ($random(seed) & 3) == 0;
            if (instr_valid) begin
                count++;
            end
        end
        if (count < 24) begin
            errors++;
            $display("Timed out with only %0d instructions under random stall", count);
        end

        // Redirect while a fetch is in flight.
        @(posedge clk);
        stall <= 1'b0;
        redirect_to(32'h80);
        wait_for_pc(32'h80);
        repeat (4) @(posedge clk);
        finish_run();
    end

endmodule

/* testbench/fetch_assert.sv */
module fetch_assert (
    input logic                               clk,
    input logic                               rst,
    input logic                               stall,
    input logic                               redirect,
    input logic [ifu_pkg::addr_width-1:0]     redirect_pc,
    input logic [ifu_pkg::data_width-1:0]     instr,
    input logic [ifu_pkg::addr_width-1:0]     instr_pc,
    input logic                               instr_valid,
    input logic                               cpu_req,
    input logic                               cpu_hit,
    input logic                               cpu_ready,
    input logic                               mem_req,
    input logic                               mem_ready
);

    logic [ifu_pkg::data_width-1:0]      golden [ifu_pkg::mem_words];
    logic [ifu_pkg::mem_index_width-1:0] word;
    logic [ifu_pkg::addr_width-1:0]      target;
    logic [ifu_pkg::addr_width-1:0]      last_pc;
    logic                                pending;
    int                                  assert_errors = 0;

    initial begin
        $readmemh("program.hex", golden);
    end

    assign word = instr_pc[ifu_pkg::offset_width +: ifu_pkg::mem_index_width];

    // Reset behaves like a redirect to the reset PC.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pending <= 1'b1;
            target  <= ifu_pkg::reset_pc;
            last_pc <= ifu_pkg::reset_pc;
        end else begin
            if (redirect) begin
                pending <= 1'b1;
                target  <= redirect_pc;
            end else if (instr_valid) begin
                pending <= 1'b0;
            end
            if (instr_valid) begin
                last_pc <= instr_pc;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Properties
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    a_golden: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> instr == golden[word])
        else begin
            $error("Delivered instruction differs from the program word at its pc");
            assert_errors++;
        end

    a_stream: assert property (@(posedge clk) disable iff (rst)
        instr_valid |-> instr_pc == (pending ? target : last_pc + ifu_pkg::pc_step))
        else begin
            $error("Delivered pc is neither the redirect target nor the next sequential pc");
            assert_errors++;
        end

    a_hit_time: assert property (@(posedge clk) disable iff (rst)
        cpu_ready && cpu_hit |-> $past(cpu_req, 2) && !mem_req && !$past(mem_req))
        else begin
            $error("Hit answer not two cycles after the request, or a refill was raised");
            assert_errors++;
        end

    a_miss_time: assert property (@(posedge clk) disable iff (rst)
        cpu_ready && !cpu_hit |-> $past(cpu_req, 6))
        else begin
            $error("Miss answer not six cycles after the request");
            assert_errors++;
        end

    // Refill request holds until the memory answers and drops right after.
    a_mem_level: assert property (@(posedge clk) disable iff (rst)
        $past(mem_req) |-> mem_req != $past(mem_ready))
        else begin
            $error("Refill request did not hold until the memory answer and then fall");
            assert_errors++;
        end

    a_stall: assert property (@(posedge clk) disable iff (rst) stall |=> !cpu_req)
        else begin
            $error("Cache request issued while decode was stalling");
            assert_errors++;
        end

    a_reset: assert property (@(posedge clk)
        $fell(rst) |-> !mem_req && !cpu_ready && !instr_valid && !cpu_req)
        else begin
            $error("Handshake outputs not low when reset is released");
            assert_errors++;
        end

endmodule

bind fetch_top fetch_assert u_fetch_assert (.*);

/* logic/fetch_top.sv */
module fetch_top (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                stall,
    input  logic                                redirect,
    input  logic [ifu_pkg::addr_width-1:0]      redirect_pc,

    output logic [ifu_pkg::data_width-1:0]      instr,
    output logic [ifu_pkg::addr_width-1:0]      instr_pc,
    output logic                                instr_valid,
    output logic [ifu_pkg::counter_width-1:0]   hit_count,
    output logic [ifu_pkg::counter_width-1:0]   miss_count
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch unit to cache
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    ifu_pkg::fetch_addr_t              cpu_addr;
    logic                              cpu_req;
    logic [ifu_pkg::data_width-1:0]    cpu_data;
    logic                              cpu_hit;
    logic                              cpu_ready;

    // Cache to memory.
    logic                              mem_req;
    logic [ifu_pkg::data_width-1:0]    mem_data;
    logic                              mem_ready;

    fetch_unit u_fetch_unit (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .cpu_addr    (cpu_addr),
        .cpu_req     (cpu_req),
        .cpu_data    (cpu_data),
        .cpu_hit     (cpu_hit),
        .cpu_ready   (cpu_ready),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid),
        .hit_count   (hit_count),
        .miss_count  (miss_count)
    );

    icache u_icache (
        .clk       (clk),
        .rst       (rst),
        .cpu_addr  (cpu_addr),
        .cpu_req   (cpu_req),
        .cpu_data  (cpu_data),
        .cpu_hit   (cpu_hit),
        .cpu_ready (cpu_ready),
        .mem_req   (mem_req),
        .mem_data  (mem_data),
        .mem_ready (mem_ready)
    );

    // Memory sees the held fetch address directly.
    inst_mem u_inst_mem (
        .clk       (clk),
        .rst       (rst),
        .mem_addr  (cpu_addr),
        .mem_req   (mem_req),
        .mem_data  (mem_data),
        .mem_ready (mem_ready)
    );

endmodule

/* logic/fetch_unit.sv */
module fetch_unit (
    input  logic                                clk,
    input  logic                                rst,

    input  logic                                stall,
    input  logic                                redirect,
    input  logic [ifu_pkg::addr_width-1:0]      redirect_pc,

    output ifu_pkg::fetch_addr_t                cpu_addr,
    output logic                                cpu_req,
    input  logic [ifu_pkg::data_width-1:0]      cpu_data,
    input  logic                                cpu_hit,
    input  logic                                cpu_ready,

    output logic [ifu_pkg::data_width-1:0]      instr,
    output logic [ifu_pkg::addr_width-1:0]      instr_pc,
    output logic                                instr_valid,
    output logic [ifu_pkg::counter_width-1:0]   hit_count,
    output logic [ifu_pkg::counter_width-1:0]   miss_count
);

    // Address of the next fetch to issue.
    ifu_pkg::fetch_addr_t pc;

    logic busy;
    logic drop;
    logic issue;
    logic accept;

    // A new request only goes out when nothing is in flight.
    assign issue  = !busy && !stall;
    // A redirect in the same cycle as the answer also throws it away.
    assign accept = cpu_ready && !drop && !redirect;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencer
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc.raw      <= ifu_pkg::reset_pc;
            busy        <= 1'b0;
            drop        <= 1'b0;
            cpu_req     <= 1'b0;
            instr_valid <= 1'b0;
        end else begin
            cpu_req     <= issue;
            instr_valid <= accept;

            if (issue) begin
                busy <= 1'b1;
            end else if (cpu_ready) begin
                busy <= 1'b0;
            end

            // Outstanding fetch is stale once the PC has been redirected.
            if (cpu_ready) begin
                drop <= 1'b0;
            end else if (redirect && busy) begin
                drop <= 1'b1;
            end

            if (redirect) begin
                pc.raw <= redirect_pc;
            end else if (accept) begin
                pc.raw <= cpu_addr.raw + ifu_pkg::pc_step;
            end
        end
    end

    // Request address and delivered instruction.
    always_ff @(posedge clk) begin
        if (issue) begin
            cpu_addr.raw <= redirect ? redirect_pc : pc.raw;
        end
        if (accept) begin
            instr    <= cpu_data;
            instr_pc <= cpu_addr.raw;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Performance counters
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Dropped fetches still count.
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit_count  <= '0;
            miss_count <= '0;
        end else if (cpu_ready) begin
            if (cpu_hit) begin
                hit_count <= hit_count + 1'b1;
            end else begin
                miss_count <= miss_count + 1'b1;
            end
        end
    end

endmodule

/* logic/icache.sv */
module icache (
    input  logic                               clk,
    input  logic                               rst,

    input  ifu_pkg::fetch_addr_t               cpu_addr,
    input  logic                               cpu_req,
    output logic [ifu_pkg::data_width-1:0]     cpu_data,
    output logic                               cpu_hit,
    output logic                               cpu_ready,

    output logic                               mem_req,
    input  logic [ifu_pkg::data_width-1:0]     mem_data,
    input  logic                               mem_ready
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Line storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [ifu_pkg::tag_width-1:0]   tag_array  [ifu_pkg::cache_lines];
    logic [ifu_pkg::data_width-1:0]  data_array [ifu_pkg::cache_lines];
    logic [ifu_pkg::cache_lines-1:0] valid;

    logic [1:0]                      state;
    logic [1:0]                      state_next;

    logic [ifu_pkg::index_width-1:0] index;
    logic                            in_compare;
    logic                            lookup_hit;
    logic                            fill;

    // The address is held by the fetch unit for the whole lookup.
    assign index      = cpu_addr.fields.index;
    assign in_compare = (state == ifu_pkg::cache_compare);
    assign lookup_hit = valid[index] && (tag_array[index] == cpu_addr.fields.tag);
    assign fill       = (state == ifu_pkg::cache_refill) && mem_ready;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Controller
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        case (state)
            ifu_pkg::cache_idle: begin
                state_next = cpu_req ? ifu_pkg::cache_compare : ifu_pkg::cache_idle;
            end
            ifu_pkg::cache_compare: begin
                state_next = lookup_hit ? ifu_pkg::cache_idle : ifu_pkg::cache_refill;
            end
            ifu_pkg::cache_refill: begin
                state_next = mem_ready ? ifu_pkg::cache_idle : ifu_pkg::cache_refill;
            end
            default: begin
                state_next = ifu_pkg::cache_idle;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= ifu_pkg::cache_idle;
            cpu_ready <= 1'b0;
            cpu_hit   <= 1'b0;
            mem_req   <= 1'b0;
            valid     <= '0;
        end else begin
            state <= state_next;

            // One-cycle answer, from the array or from the refill.
            cpu_ready <= (in_compare && lookup_hit) || fill;
            cpu_hit   <= in_compare && lookup_hit;

            // Refill request is a level held until the memory answers.
            mem_req <= (in_compare && !lookup_hit)
                       || ((state == ifu_pkg::cache_refill) && !mem_ready);

            if (fill) begin
                valid[index] <= 1'b1;
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data path
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk) begin
        if (in_compare && lookup_hit) begin
            cpu_data <= data_array[index];
        end else if (fill) begin
            cpu_data <= mem_data;
        end
    end

    // A refill always replaces whatever the indexed line held.
    always_ff @(posedge clk) begin
        if (fill) begin
            tag_array[index]  <= cpu_addr.fields.tag;
            data_array[index] <= mem_data;
        end
    end

endmodule

/* logic/inst_mem.sv */
module inst_mem (
    input  logic                               clk,
    input  logic                               rst,

    input  ifu_pkg::fetch_addr_t               mem_addr,
    input  logic                               mem_req,
    output logic [ifu_pkg::data_width-1:0]     mem_data,
    output logic                               mem_ready
);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Program storage
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    logic [ifu_pkg::data_width-1:0] mem [ifu_pkg::mem_words];

    logic [ifu_pkg::mem_index_width-1:0] word_index;
    logic [ifu_pkg::lat_width-1:0]       lat_cnt;
    logic                                served;
    logic                                fire;

    initial begin
        $readmemh("program.hex", mem);
    end

    // Word address, upper bits ignored so the program wraps.
    assign word_index = mem_addr.raw[ifu_pkg::offset_width +: ifu_pkg::mem_index_width];

    // Answer on the last counted cycle of the request.
    assign fire = mem_req && !served && (lat_cnt == ifu_pkg::lat_last);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Latency counter
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lat_cnt   <= '0;
            served    <= 1'b0;
            mem_ready <= 1'b0;
        end else begin
            mem_ready <= fire;

            if (!mem_req) begin
                lat_cnt <= '0;
                served  <= 1'b0;
            end else if (fire) begin
                lat_cnt <= '0;
                served  <= 1'b1;
            end else if (!served) begin
                lat_cnt <= lat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            mem_data <= mem[word_index];
        end
    end

endmodule

/* logic/ifu_pkg.sv */
package ifu_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Address and data sizes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int addr_width    = 32;
    localparam int data_width    = 32;
    localparam int cache_lines   = 16;
    localparam int index_width   = $clog2(cache_lines);
    localparam int offset_width  = 2;
    localparam int tag_width     = addr_width - index_width - offset_width;

    // Instruction memory wraps above its own index bits.
    localparam int mem_words       = 64;
    localparam int mem_index_width = $clog2(mem_words);
    localparam int mem_latency     = 3;
    localparam int lat_width       = $clog2(mem_latency);
    localparam logic [lat_width-1:0] lat_last = lat_width'(mem_latency - 1);

    // Fetch sequencing.
    localparam logic [addr_width-1:0] reset_pc = '0;
    localparam logic [addr_width-1:0] pc_step  = 4;
    localparam int counter_width = 16;

    // Cache controller states.
    localparam logic [1:0] cache_idle    = 2'd0;
    localparam logic [1:0] cache_compare = 2'd1;
    localparam logic [1:0] cache_refill  = 2'd2;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Fetch address, raw word or cache fields
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef union packed {
        logic [addr_width-1:0] raw;
        struct packed {
            logic [tag_width-1:0]    tag;
            logic [index_width-1:0]  index;
            logic [offset_width-1:0] offset;
        } fields;
    } fetch_addr_t;

endpackage
